// File: hdl/counting_filter.sv
// ====================
// Top of the counting filter: remove queue, update pipeline
// and the value and is-zero lookup ports
// ====================

`timescale 1ns/1ps

module counting_filter
(
    input  logic                      clk,
    input  logic                      reset,

    // Inserts are never stalled
    input  filter_pkg::lookup_req_t    insert_req,

    // Removes are queued, the client watches remove_not_full
    input  filter_pkg::lookup_req_t    remove_req,
    output logic                      remove_not_full,
    output logic                      remove_almost_full,

    // Count of a bucket, two cycles after the request
    input  filter_pkg::lookup_req_t    value_req,
    output filter_pkg::bucket_value_t  value_result,

    // Empty flag of a bucket, two cycles after the request
    input  filter_pkg::lookup_req_t    zero_req,
    output logic                      zero_result
);

    import filter_pkg::*;

    // Update chosen by the decode stage
    update_req_t update_req;

    // Write broadcast from the execute stage
    mem_write_t mem_write;

    // ====================
    // Decode and execute
    // ====================

    remove_queue u_remove_queue (
        .clk                (clk),
        .reset              (reset),
        .insert_req         (insert_req),
        .remove_req         (remove_req),
        .remove_not_full    (remove_not_full),
        .remove_almost_full (remove_almost_full),
        .update_req         (update_req)
    );

    update_pipeline u_update_pipeline (
        .clk        (clk),
        .reset      (reset),
        .update_req (update_req),
        .mem_write  (mem_write)
    );

    // ====================
    // Lookup ports
    // ====================

    // Counts start at zero
    lookup_port #(
        .payload_t   (bucket_value_t),
        .RESET_VALUE ('0)
    ) u_value_port (
        .clk     (clk),
        .reset   (reset),
        .req     (value_req),
        .wr_en   (mem_write.en),
        .wr_idx  (mem_write.idx),
        .wr_data (mem_write.value),
        .result  (value_result)
    );

    // Every bucket starts out empty, so the flag resets to one
    lookup_port #(
        .payload_t   (logic),
        .RESET_VALUE (1'b1)
    ) u_zero_port (
        .clk     (clk),
        .reset   (reset),
        .req     (zero_req),
        .wr_en   (mem_write.en),
        .wr_idx  (mem_write.idx),
        .wr_data (mem_write.is_zero),
        .result  (zero_result)
    );

endmodule

// File: hdl/filter_pkg.sv
// ====================
// Shared types of the counting filter: bucket index and value,
// the update request, the write broadcast and the lookup request
// ====================

`include "filter_settings.svh"

package filter_pkg;

    // A bucket number
    typedef logic [$clog2(`FILTER_N_BUCKETS)-1:0] bucket_idx_t;

    // A bucket count, unsigned and wrapping
    typedef logic [`FILTER_BUCKET_BITS-1:0] bucket_value_t;

    // The update entering the execute pipeline
    typedef struct packed {
        logic        en;
        bucket_idx_t idx;
        logic        is_insert;
    } update_req_t;

    // Write broadcast from the execute pipeline to every memory copy
    typedef struct packed {
        logic          en;
        bucket_idx_t   idx;
        bucket_value_t value;
        logic          is_zero;
    } mem_write_t;

    // One read request, also used for insert and remove requests
    typedef struct packed {
        logic        en;
        bucket_idx_t idx;
    } lookup_req_t;

endpackage

// File: hdl/filter_settings.svh
// ====================
// Sizing macros for the counting filter: bucket count, bucket width
// and the depth and threshold of the remove FIFO
// ====================

`ifndef FILTER_SETTINGS_SVH
`define FILTER_SETTINGS_SVH

// Number of buckets in the single bank
`define FILTER_N_BUCKETS 16

// Width of each bucket counter
`define FILTER_BUCKET_BITS 4

// Entries in the remove FIFO
`define FILTER_REMOVE_DEPTH 8

// Free entries at or below which almost_full is raised
`define FILTER_REMOVE_THRESHOLD 2

`endif

// File: hdl/lookup_port.sv
// ====================
// Result stage: one memory copy of a chosen payload with a
// two-cycle read, bypassed against the write broadcast
// ====================

`timescale 1ns/1ps

`include "filter_settings.svh"

module lookup_port
#(
    parameter type    payload_t   = logic,
    parameter payload_t RESET_VALUE = '0
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  filter_pkg::lookup_req_t req,
    input  logic                   wr_en,
    input  filter_pkg::bucket_idx_t wr_idx,
    input  payload_t               wr_data,
    output payload_t               result
);

    import filter_pkg::*;

    // Local copy of one field of every bucket
    payload_t mem [`FILTER_N_BUCKETS];

    // Registered read and output register
    payload_t rd_1;
    payload_t rd_2;

    // Bypass state, indexed by lookup stage
    logic        byp_en  [1:2];
    payload_t    byp_val [1:2];
    bucket_idx_t byp_idx;

    logic hit_0;
    logic hit_1;

    // ====================
    // Memory copy
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < `FILTER_N_BUCKETS; b++)
            begin
                mem[b] <= RESET_VALUE;
            end
        end
        else if (wr_en)
        begin
            mem[wr_idx] <= wr_data;
        end
    end

    // The read port is only enabled for a real request
    always_ff @(posedge clk)
    begin
        if (req.en)
        begin
            rd_1 <= mem[req.idx];
        end
        rd_2 <= rd_1;
    end

    // ====================
    // Bypass
    // ====================

    // The memory read misses the writes in the request cycle and the next
    // one, so each of those two stages checks the broadcast
    assign hit_0 = wr_en && (wr_idx == req.idx);
    assign hit_1 = wr_en && (wr_idx == byp_idx);

    always_ff @(posedge clk)
    begin
        byp_idx    <= req.idx;
        byp_en[1]  <= hit_0;
        byp_val[1] <= wr_data;

        // A newer write to the same bucket replaces the older one
        if (hit_1)
        begin
            byp_en[2]  <= 1'b1;
            byp_val[2] <= wr_data;
        end
        else
        begin
            byp_en[2]  <= byp_en[1];
            byp_val[2] <= byp_val[1];
        end

        if (reset)
        begin
            byp_en[1] <= 1'b0;
            byp_en[2] <= 1'b0;
        end
    end

    // Bypassed data wins over the memory data
    assign result = byp_en[2] ? byp_val[2] : rd_2;

endmodule

// File: hdl/remove_queue.sv
// ====================
// Decode stage with the remove FIFO and the choice of one update per cycle
// ====================

`timescale 1ns/1ps

`include "filter_settings.svh"

module remove_queue
#(
    parameter int DEPTH     = `FILTER_REMOVE_DEPTH,
    parameter int THRESHOLD = `FILTER_REMOVE_THRESHOLD
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  filter_pkg::lookup_req_t insert_req,
    input  filter_pkg::lookup_req_t remove_req,
    output logic                   remove_not_full,
    output logic                   remove_almost_full,
    output filter_pkg::update_req_t update_req
);

    import filter_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Circular buffer of bucket indices waiting to be removed
    bucket_idx_t fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic push;
    logic pop;
    logic not_empty;

    // ====================
    // Flags and update choice
    // ====================

    assign not_empty          = (count != '0);
    assign remove_not_full    = (count != CNT_W'(DEPTH));
    // Raised once the free entries drop to the threshold
    assign remove_almost_full = (count >= CNT_W'(DEPTH - THRESHOLD));

    // The client honors not_full and the guard keeps the FIFO intact
    assign push = remove_req.en && remove_not_full;

    // An insert always owns the update port and a remove takes only idle cycles
    assign pop = !insert_req.en && not_empty;

    always_comb
    begin
        update_req.en        = insert_req.en || not_empty;
        update_req.is_insert = insert_req.en;
        update_req.idx       = insert_req.en ? insert_req.idx : fifo_mem[rd_ptr];
    end

    // ====================
    // FIFO state
    // ====================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                // Pointers wrap at DEPTH so that depths other than powers of two work
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A push and a pop in the same cycle leave the count unchanged
            if (push && !pop)
            begin
                count <= count + 1'b1;
            end
            else if (pop && !push)
            begin
                count <= count - 1'b1;
            end
        end
    end

    // A push writes the bucket index at the tail
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            fifo_mem[wr_ptr] <= remove_req.idx;
        end
    end

endmodule

// File: hdl/update_pipeline.sv
// ====================
// Execute stage with the bypassed read-modify-write pipeline over the
// master bucket memory and its write broadcast to the memory copies
// ====================

`timescale 1ns/1ps

`include "filter_settings.svh"

module update_pipeline
(
    input  logic                   clk,
    input  logic                   reset,
    input  filter_pkg::update_req_t update_req,
    output filter_pkg::mem_write_t  mem_write
);

    import filter_pkg::*;

    // The in-flight delta covers three updates at most and spans -3 to +3
    typedef logic signed [2:0] delta_t;

    localparam int EXT_W = `FILTER_BUCKET_BITS - $bits(delta_t);

    // Master copy of every bucket count
    bucket_value_t mem [`FILTER_N_BUCKETS];

    // Two-stage read of the master memory
    bucket_value_t rd_val_1;
    bucket_value_t rd_val_2;

    // Stage 0 is update_req itself and stages 1 to 3 are registered copies
    // Stage 3 is needed because the delta is built one cycle late
    update_req_t stg [1:3];

    delta_t delta_d;
    delta_t delta_q;
    bucket_value_t wr_value;

    // An insert counts +1 and a remove counts -1
    function automatic delta_t step(input logic is_insert);
        return is_insert ? delta_t'(1) : delta_t'(-1);
    endfunction

    // ====================
    // Pipeline stages
    // ====================

    always_ff @(posedge clk)
    begin
        stg[1] <= update_req;
        stg[2] <= stg[1];
        stg[3] <= stg[2];

        // Reset clears the stage enables
        if (reset)
        begin
            stg[1].en <= 1'b0;
            stg[2].en <= 1'b0;
            stg[3].en <= 1'b0;
        end
    end

    // The read is sampled at the end of the request cycle, so it misses
    // the writes of the two updates ahead of it
    always_ff @(posedge clk)
    begin
        rd_val_1 <= mem[update_req.idx];
        rd_val_2 <= rd_val_1;
        delta_q  <= delta_d;
    end

    // ====================
    // In-flight delta
    // ====================

    always_comb
    begin
        delta_d = '0;

        // The update itself sits in stage 1
        if (stg[1].en)
        begin
            delta_d = delta_d + step(stg[1].is_insert);
        end

        // Older same-bucket updates whose writes the read did not see
        if (stg[2].en && (stg[2].idx == stg[1].idx))
        begin
            delta_d = delta_d + step(stg[2].is_insert);
        end
        if (stg[3].en && (stg[3].idx == stg[1].idx))
        begin
            delta_d = delta_d + step(stg[3].is_insert);
        end
    end

    // Sign-extend the delta and add it to the stale count
    assign wr_value = rd_val_2 + {{EXT_W{delta_q[2]}}, delta_q};

    // ====================
    // Write broadcast
    // ====================

    always_comb
    begin
        mem_write.en      = stg[2].en;
        mem_write.idx     = stg[2].idx;
        mem_write.value   = wr_value;
        mem_write.is_zero = (wr_value == '0);
    end

    // Reset clears the master memory to all-zero counts
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < `FILTER_N_BUCKETS; b++)
            begin
                mem[b] <= '0;
            end
        end
        else if (mem_write.en)
        begin
            mem[mem_write.idx] <= wr_value;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
out=$(verilator --binary --timing -f sources.f --top-module filter_tb -o filter_sim 2>&1 \
    && ./obj_dir/filter_sim 2>&1)
echo "$out"
echo "$out" | grep -qxF '>>> PASS' \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: sources.f
+incdir+hdl
+incdir+testbench
hdl/filter_pkg.sv
hdl/remove_queue.sv
hdl/update_pipeline.sv
hdl/lookup_port.sv
hdl/counting_filter.sv
testbench/filter_tb.sv

// File: testbench/filter_tests.svh
// ====================
// Directed tests of the counting filter, one task per behavior
// ====================

    // Removes of one bucket that sit in the model queue
    function automatic int queued_removes(input int b);
        int n;
        n = 0;
        foreach (model_q[i])
        begin
            if (int'(model_q[i]) == b)
            begin
                n++;
            end
        end
        return n;
    endfunction

    // Every bucket starts with count 0 and is-zero 1
    task automatic after_reset();
        start_test("after_reset");
        sweep();
        finish_test();
    endtask

    // Same-bucket updates back to back, then two buckets interleaved
    task automatic back_to_back_inserts();
        start_test("back_to_back_inserts");
        repeat (6)
        begin
            nxt_ins = on_bucket(5);
            tick();
        end
        // Bucket 5 recurs two cycles apart, which is the stage 3 case
        for (int i = 0; i < 8; i++)
        begin
            nxt_ins = on_bucket((i % 2 == 0) ? 5 : 10);
            tick();
        end
        idle(1);
        sweep();
        finish_test();
    endtask

    // A read in the insert's own cycle misses it, one cycle later sees it
    task automatic read_after_insert();
        start_test("read_after_insert");
        for (int k = 0; k < 4; k++)
        begin
            nxt_ins  = on_bucket(2 + 3 * k);
            nxt_val  = on_bucket(2 + 3 * k);
            nxt_zero = on_bucket(2 + 3 * k);
            tick();
            nxt_val  = on_bucket(2 + 3 * k);
            nxt_zero = on_bucket(2 + 3 * k);
            tick();
        end
        idle(2);
        finish_test();
    endtask

    task automatic removes_during_inserts();
        start_test("removes_during_inserts");
        for (int i = 0; i < 6; i++)
        begin
            nxt_ins = on_bucket(1 + i % 2);
            tick();
        end
        // Buckets 1 and 2 keep their counts while the stream owns the port
        for (int i = 0; i < 8; i++)
        begin
            nxt_ins  = on_bucket(8 + i);
            nxt_val  = on_bucket(1);
            nxt_zero = on_bucket(2);
            if (i < 5)
            begin
                nxt_rem = on_bucket(1 + i % 2);
            end
            tick();
        end
        idle(DEPTH + 4);
        sweep();
        finish_test();
    endtask

    task automatic queue_flags();
        start_test("queue_flags");
        repeat (8)
        begin
            nxt_ins = on_bucket(4);
            tick();
        end
        // Push removes behind a steady insert stream until the FIFO is full
        for (int i = 0; i < 10; i++)
        begin
            nxt_ins = on_bucket(12);
            if (model_q.size() < DEPTH)
            begin
                nxt_rem = on_bucket(4);
            end
            tick();
        end
        check_flag("remove_not_full", remove_not_full, 1'b0);
        check_flag("remove_almost_full", remove_almost_full, 1'b1);
        idle(DEPTH + 4);
        check_flag("remove_not_full", remove_not_full, 1'b1);
        check_flag("remove_almost_full", remove_almost_full, 1'b0);
        sweep();
        finish_test();
    endtask

    task automatic random_mix();
        int r;
        int ib;
        int rb;
        start_test("random_mix");
        for (int i = 0; i < 96; i++)
        begin
            r = $random(seed);
            // Updates stay on four buckets so they collide in the pipeline
            ib = (r >> 4) & 3;
            rb = (r >> 6) & 3;
            if (((r & 3) != 0) && (model[ib] != 4'hf))
            begin
                nxt_ins = on_bucket(ib);
            end
            // A remove is only pushed while its bucket stays above zero
            if (((r & 4) != 0) && (model_q.size() < DEPTH)
                && (int'(model[rb]) > queued_removes(rb)))
            begin
                nxt_rem = on_bucket(rb);
            end
            nxt_val  = on_bucket((r >> 8) & 15);
            nxt_zero = on_bucket((r >> 12) & 15);
            tick();
        end
        idle(DEPTH + 4);
        sweep();
        finish_test();
    endtask

// File: testbench/filter_tb.sv
// ====================
// Counting filter testbench with clock, reset, reference model,
// compare tasks, watchdog and summary
// ====================

`timescale 1ns/1ps

`include "filter_settings.svh"

module filter_tb;

    import filter_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int DEPTH       = `FILTER_REMOVE_DEPTH;
    localparam int THRESHOLD   = `FILTER_REMOVE_THRESHOLD;
    // The six tests take about this many cycles together
    localparam int TEST_CYCLES = 340;

    logic          clk = 1'b0;
    logic          reset;
    lookup_req_t   insert_req;
    lookup_req_t   remove_req;
    lookup_req_t   value_req;
    lookup_req_t   zero_req;
    logic          remove_not_full;
    logic          remove_almost_full;
    bucket_value_t value_result;
    logic          zero_result;

    // Tick drives these requests in the coming cycle
    lookup_req_t nxt_ins;
    lookup_req_t nxt_rem;
    lookup_req_t nxt_val;
    lookup_req_t nxt_zero;

    // The reference model holds the bucket counts and the removes still queued
    bucket_value_t model [`FILTER_N_BUCKETS];
    bucket_idx_t   model_q [$];

    // Expected read results where slot 1 is due in the current cycle
    logic          val_pend_en [2];
    bucket_value_t val_pend_exp [2];
    logic          zero_pend_en [2];
    logic          zero_pend_exp [2];

    int    seed = 32'h4a67_5a7f;
    int    n_checks = 0;
    int    n_errors = 0;
    int    n_tests = 0;
    int    test_errors;
    string test_name;

    always #(CLK_PERIOD / 2) clk = ~clk;

    counting_filter UUT (
        .clk                (clk),
        .reset              (reset),
        .insert_req         (insert_req),
        .remove_req         (remove_req),
        .remove_not_full    (remove_not_full),
        .remove_almost_full (remove_almost_full),
        .value_req          (value_req),
        .value_result       (value_result),
        .zero_req           (zero_req),
        .zero_result        (zero_result)
    );

    // ====================
    // Compare tasks
    // ====================

    task automatic check_value(input string name, input bucket_value_t actual,
                               input bucket_value_t expected);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("[FAIL] t=%0t %s: expected %0d, got %0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_zero(input string name, input logic actual, input logic expected);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("[FAIL] t=%0t %s: expected %0b, got %0b", $time, name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("[FAIL] t=%0t %s: expected %0b, got %0b", $time, name, expected, actual);
        end
    endtask

    // ====================
    // Stimulus and model
    // ====================

    function automatic lookup_req_t on_bucket(input int b);
        lookup_req_t r;
        r.en  = 1'b1;
        r.idx = bucket_idx_t'(b);
        return r;
    endfunction

    // Reset the DUT for 8 cycles and clear the model with it
    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset      = 1'b1;
        insert_req = '0;
        remove_req = '0;
        value_req  = '0;
        zero_req   = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int b = 0; b < `FILTER_N_BUCKETS; b++)
        begin
            model[b] = '0;
        end
        model_q.delete();
        for (int s = 0; s < 2; s++)
        begin
            val_pend_en[s]  = 1'b0;
            zero_pend_en[s] = 1'b0;
        end
    endtask

    // One cycle checks the reads that are due, drives the requests and
    // advances the model with inserts first and removes in insert-free cycles
    task automatic tick();
        bit          was_full;
        bucket_idx_t head;
        @(posedge clk);
        #1;
        if (val_pend_en[1])
        begin
            check_value("value_result", value_result, val_pend_exp[1]);
        end
        if (zero_pend_en[1])
        begin
            check_zero("zero_result", zero_result, zero_pend_exp[1]);
        end

        // Flags follow the queue fill at the start of the cycle
        was_full = (model_q.size() == DEPTH);
        check_flag("remove_not_full", remove_not_full, !was_full);
        // Almost full once no more than THRESHOLD entries are free
        check_flag("remove_almost_full", remove_almost_full,
                   (DEPTH - model_q.size()) <= THRESHOLD);

        insert_req = nxt_ins;
        remove_req = nxt_rem;
        value_req  = nxt_val;
        zero_req   = nxt_zero;

        // A read sees every update issued before its own cycle
        val_pend_en[1]   = val_pend_en[0];
        val_pend_exp[1]  = val_pend_exp[0];
        zero_pend_en[1]  = zero_pend_en[0];
        zero_pend_exp[1] = zero_pend_exp[0];
        val_pend_en[0]   = nxt_val.en;
        val_pend_exp[0]  = model[nxt_val.idx];
        zero_pend_en[0]  = nxt_zero.en;
        zero_pend_exp[0] = (model[nxt_zero.idx] == '0);

        // Inserts go first and a queued remove only takes an insert-free cycle
        if (nxt_ins.en)
        begin
            model[nxt_ins.idx] = model[nxt_ins.idx] + 1'b1;
        end
        else if (model_q.size() != 0)
        begin
            head        = model_q.pop_front();
            model[head] = model[head] - 1'b1;
        end
        if (nxt_rem.en && !was_full)
        begin
            model_q.push_back(nxt_rem.idx);
        end

        nxt_ins  = '0;
        nxt_rem  = '0;
        nxt_val  = '0;
        nxt_zero = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) tick();
    endtask

    // Read every bucket's value and is-zero flag, then let the last reads land
    task automatic sweep();
        for (int b = 0; b < `FILTER_N_BUCKETS; b++)
        begin
            nxt_val  = on_bucket(b);
            nxt_zero = on_bucket(b);
            tick();
        end
        idle(2);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = n_errors;
        apply_reset();
    endtask

    task automatic finish_test();
        n_tests++;
        if (n_errors == test_errors)
        begin
            $display("%s: ok", test_name);
        end
        else
        begin
            $display("%s: %0d errors", test_name, n_errors - test_errors);
        end
    endtask

    `include "filter_tests.svh"

    // ====================
    // Main sequence and watchdog
    // ====================

    initial
    begin
        reset      = 1'b1;
        insert_req = '0;
        remove_req = '0;
        value_req  = '0;
        zero_req   = '0;
        nxt_ins    = '0;
        nxt_rem    = '0;
        nxt_val    = '0;
        nxt_zero   = '0;

        after_reset();
        back_to_back_inserts();
        read_after_insert();
        removes_during_inserts();
        queue_flags();
        random_mix();

        $display("Tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial
    begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish within %0d cycles",
                 TEST_CYCLES * 2);
        $display(">>> FAIL");
        $finish;
    end

endmodule
